// File: apbPkg.sv
`default_nettype none

package apbPkg;

    // bus geometry
    localparam int apbAddrWidth = 16;  // PADDR[15:12] port, PADDR[4:2] slot
    localparam int apbDataWidth = 32;

    // what the requester drives into the slave
    typedef struct packed {
        logic [apbAddrWidth-1:0] paddr;
        logic                    psel;     // single slave select
        logic                    penable;  // high in the access phase
        logic                    pwrite;
        logic [apbDataWidth-1:0] pwdata;
    } apbReq_t;

    // what the slave answers
    typedef struct packed {
        logic                    pready;   // tied high in this design
        logic [apbDataWidth-1:0] prdata;
        logic                    pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

// File: gpioApbDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module gpioApbDecoder
    import apbPkg::*;
    import gpioPkg::*;
(
    input  apbReq_t                 req,
    output apbRsp_t                 rsp,
    output regAccess_t              accA,
    output regAccess_t              accB,
    input  portView_t               viewA,
    input  portView_t               viewB,
    input  logic [gpioPinCount-1:0] idrA,
    input  logic [gpioPinCount-1:0] idrB
);

    logic [3:0]              portSel;      // PADDR[15:12]
    logic [2:0]              slot;         // PADDR[4:2]
    logic                    accessPhase;
    logic                    portMapped;
    logic                    hitA;
    logic                    hitB;
    logic                    errFlag;
    logic                    wrLegal;
    portView_t               viewSel;
    logic [gpioPinCount-1:0] idrSel;
    logic [apbDataWidth-1:0] rdWord;

    assign portSel     = req.paddr[15:12];
    assign slot        = req.paddr[4:2];
    assign accessPhase = req.psel & req.penable;

    // only the first portCount ports exist
    assign portMapped = (portSel < 4'(portCount));
    assign hitA       = (portSel == 4'd0);
    assign hitB       = (portSel == 4'd1);

    // slave error cases
    always_comb begin
        errFlag = 1'b0;
        if (accessPhase) begin
            if (!portMapped)
                errFlag = 1'b1;                            // no such port
            else if (slot == slotRsvd)
                errFlag = 1'b1;                            // hole in the map
            else if (req.pwrite && slot == slotIdr)
                errFlag = 1'b1;                            // IDR is read only
        end
    end

    // any error-free write in the access phase reaches a register block
    assign wrLegal = accessPhase & req.pwrite & ~errFlag;

    always_comb begin
        accA.wrEn  = wrLegal & hitA;
        accA.slot  = slot;
        accA.wdata = req.pwdata;
        accB.wrEn  = wrLegal & hitB;
        accB.slot  = slot;
        accB.wdata = req.pwdata;
    end

    // readback source of the addressed port
    assign viewSel = hitB ? viewB : viewA;
    assign idrSel  = hitB ? idrB : idrA;

    always_comb begin
        case (slot)
            slotCrl:  rdWord = viewSel.crl.raw;
            slotCrh:  rdWord = viewSel.crh.raw;
            slotIdr:  rdWord = {{(apbDataWidth-gpioPinCount){1'b0}}, idrSel};
            slotOdr:  rdWord = {{(apbDataWidth-gpioPinCount){1'b0}}, viewSel.odr};
            slotLckr: rdWord = {{(apbDataWidth-lckKeyBit-1){1'b0}}, viewSel.lckr};
            default:  rdWord = '0;                         // BSRR, BRR read zero
        endcase
    end

    always_comb begin
        rsp.pready  = 1'b1;                                // no wait states
        rsp.pslverr = errFlag;
        if (accessPhase && !req.pwrite && !errFlag)
            rsp.prdata = rdWord;
        else
            rsp.prdata = '0;                               // idle, writes, errors
    end

endmodule

`default_nettype wire

// File: gpioPinDriver.sv
`timescale 1ns/1ns
`default_nettype none

module gpioPinDriver
    import gpioPkg::*;
(
    input  logic                    io_apb_PCLK,
    input  logic                    io_apb_PRESET,
    input  portView_t               view,
    input  logic [gpioPinCount-1:0] afio,    // alternate function outputs
    input  logic [gpioPinCount-1:0] padIn,   // raw pad level, asynchronous
    output logic [gpioPinCount-1:0] padOut,
    output logic [gpioPinCount-1:0] padOe,   // 1 drives the pad
    output logic [gpioPinCount-1:0] idr
);

    pinCfg_t [gpioPinCount-1:0] cfg;        // nibble per pin, pin 0 lowest
    logic    [gpioPinCount-1:0] isOutput;
    logic    [gpioPinCount-1:0] openDrain;
    logic    [gpioPinCount-1:0] pinSrc;     // level the pin should show
    logic    [gpioPinCount-1:0] syncStage;  // first synchronizer flop

    // CRH covers the upper eight pins
    assign cfg = {view.crh.pin, view.crl.pin};

    always_comb begin
        for (int i = 0; i < gpioPinCount; i++) begin
            isOutput[i]  = (cfg[i].mode != modeInput);
            openDrain[i] = cfg[i].cnf[0];
            pinSrc[i]    = cfg[i].cnf[1] ? afio[i] : view.odr[i];  // AF or ODR

            if (!isOutput[i]) begin
                padOe[i]  = 1'b0;                  // input, pad floats
                padOut[i] = 1'b0;
            end else if (openDrain[i]) begin
                padOe[i]  = ~pinSrc[i];            // only pull low
                padOut[i] = 1'b0;
            end else begin
                padOe[i]  = 1'b1;                  // push-pull
                padOut[i] = pinSrc[i];
            end
        end
    end

    // two flop synchronizer, sampled in every mode
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            syncStage <= '0;
            idr       <= '0;
        end else begin
            syncStage <= padIn;
            idr       <= syncStage;  // IDR lags padIn by two edges
        end
    end

endmodule

`default_nettype wire

// File: gpioPkg.sv
`default_nettype none

package gpioPkg;

    // port geometry
    localparam int gpioPinCount = 16;
    localparam int portCount    = 2;                  // port A and port B
    localparam int crPinCount   = gpioPinCount / 2;   // nibbles per CR word
    localparam int lckKeyBit    = gpioPinCount;       // key sits just above the mask

    // register slots, PADDR[4:2]
    localparam logic [2:0] slotCrl  = 3'd0;
    localparam logic [2:0] slotCrh  = 3'd1;
    localparam logic [2:0] slotIdr  = 3'd2;  // read only
    localparam logic [2:0] slotOdr  = 3'd3;
    localparam logic [2:0] slotBsrr = 3'd4;  // write only
    localparam logic [2:0] slotBrr  = 3'd5;  // write only
    localparam logic [2:0] slotLckr = 3'd6;
    localparam logic [2:0] slotRsvd = 3'd7;  // unmapped

    localparam logic [1:0] modeInput = 2'b00;  // any other MODE drives the pad

    // one pin nibble
    typedef struct packed {
        logic [1:0] cnf;   // [1] alt function source, [0] open drain
        logic [1:0] mode;  // 00 input
    } pinCfg_t;

    // a CR word as the bus sees it or as eight pin nibbles
    typedef union packed {
        logic [31:0]              raw;
        pinCfg_t [crPinCount-1:0] pin;  // pin[0] in bits 3:0
    } crWord_u;

    // write request for one port
    typedef struct packed {
        logic        wrEn;   // one cycle, access phase only
        logic [2:0]  slot;
        logic [31:0] wdata;
    } regAccess_t;

    // register contents of one port
    typedef struct packed {
        crWord_u                 crl;   // pins 7:0
        crWord_u                 crh;   // pins 15:8
        logic [gpioPinCount-1:0] odr;
        logic [lckKeyBit:0]      lckr;  // key in the top bit
    } portView_t;

endpackage

`default_nettype wire

// File: gpioPortRegs.sv
`timescale 1ns/1ns
`default_nettype none

module gpioPortRegs
    import gpioPkg::*;
(
    input  logic       io_apb_PCLK,
    input  logic       io_apb_PRESET,
    input  regAccess_t acc,
    output portView_t  view
);

    // port registers
    crWord_u                 crl;
    crWord_u                 crh;
    logic [gpioPinCount-1:0] odr;
    logic [lckKeyBit:0]      lckr;

    // write side helpers
    crWord_u                 wrWord;     // incoming CR data split per pin
    crWord_u                 crlMerged;
    crWord_u                 crhMerged;
    logic [gpioPinCount-1:0] lockMask;
    logic [gpioPinCount-1:0] loBits;     // ODR set half of BSRR, all of BRR
    logic [gpioPinCount-1:0] hiBits;     // ODR reset half of BSRR
    logic                    lckOpen;

    assign wrWord.raw = acc.wdata;
    assign lockMask   = lckr[gpioPinCount-1:0];
    assign loBits     = acc.wdata[gpioPinCount-1:0];
    assign hiBits     = acc.wdata[2*gpioPinCount-1:gpioPinCount];
    assign lckOpen    = ~lckr[lckKeyBit];  // lock not yet latched

    // per nibble merge, locked pins hold their old config
    always_comb begin
        crlMerged = crl;
        crhMerged = crh;
        for (int i = 0; i < crPinCount; i++) begin
            if (!lockMask[i])
                crlMerged.pin[i] = wrWord.pin[i];
            if (!lockMask[i + crPinCount])
                crhMerged.pin[i] = wrWord.pin[i];  // CRH nibble i is pin i+8
        end
    end

    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            crl.raw <= '0;  // all pins input
            crh.raw <= '0;
            odr     <= '0;
            lckr    <= '0;
        end else if (acc.wrEn) begin
            case (acc.slot)
                slotCrl: crl <= crlMerged;
                slotCrh: crh <= crhMerged;
                slotOdr: odr <= loBits;                    // upper half ignored
                slotBsrr: begin
                    // set applied last so it wins over reset
                    odr <= (odr & ~hiBits) | loBits;
                end
                slotBrr: odr <= odr & ~loBits;
                slotLckr: begin
                    // key write latches the mask once, then frozen till reset
                    if (lckOpen && acc.wdata[lckKeyBit])
                        lckr <= acc.wdata[lckKeyBit:0];
                end
                default: ;                                 // IDR and slot 7 never get here
            endcase
        end
    end

    assign view = '{crl: crl, crh: crh, odr: odr, lckr: lckr};

endmodule

`default_nettype wire

// File: gpioRouter.f
apbPkg.sv
gpioPkg.sv
gpioApbDecoder.sv
gpioPortRegs.sv
gpioPinDriver.sv
gpioRouter.sv
gpioRouterTb.sv

// File: gpioRouter.sv
`timescale 1ns/1ns
`default_nettype none

module gpioRouter
    import apbPkg::*;
    import gpioPkg::*;
(
    input  logic                    io_apb_PCLK,
    input  logic                    io_apb_PRESET,
    input  logic [apbAddrWidth-1:0] io_apb_PADDR,
    input  logic                    io_apb_PSEL,
    input  logic                    io_apb_PENABLE,
    input  logic                    io_apb_PWRITE,
    input  logic [apbDataWidth-1:0] io_apb_PWDATA,
    output logic                    io_apb_PREADY,
    output logic [apbDataWidth-1:0] io_apb_PRDATA,
    output logic                    io_apb_PSLVERROR,

    input  logic [gpioPinCount-1:0] afioA,
    input  logic [gpioPinCount-1:0] afioB,
    input  logic [gpioPinCount-1:0] padInA,
    input  logic [gpioPinCount-1:0] padInB,
    output logic [gpioPinCount-1:0] padOutA,
    output logic [gpioPinCount-1:0] padOutB,
    output logic [gpioPinCount-1:0] padOeA,
    output logic [gpioPinCount-1:0] padOeB
);

    apbReq_t                 req;
    apbRsp_t                 rsp;
    regAccess_t              accA;
    regAccess_t              accB;
    portView_t               viewA;
    portView_t               viewB;
    logic [gpioPinCount-1:0] idrA;
    logic [gpioPinCount-1:0] idrB;

    // bus pins into one request word
    assign req = '{paddr:   io_apb_PADDR,
                   psel:    io_apb_PSEL,
                   penable: io_apb_PENABLE,
                   pwrite:  io_apb_PWRITE,
                   pwdata:  io_apb_PWDATA};

    assign io_apb_PREADY    = rsp.pready;
    assign io_apb_PRDATA    = rsp.prdata;
    assign io_apb_PSLVERROR = rsp.pslverr;

    gpioApbDecoder u_decoder (
        .req  (req),
        .rsp  (rsp),
        .accA (accA),
        .accB (accB),
        .viewA(viewA),
        .viewB(viewB),
        .idrA (idrA),
        .idrB (idrB)
    );

    // port A, PADDR[15:12] == 0
    gpioPortRegs u_regsA (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET),
        .acc          (accA),
        .view         (viewA)
    );

    gpioPinDriver u_pinsA (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET),
        .view         (viewA),
        .afio         (afioA),
        .padIn        (padInA),
        .padOut       (padOutA),
        .padOe        (padOeA),
        .idr          (idrA)
    );

    // port B, PADDR[15:12] == 1
    gpioPortRegs u_regsB (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET),
        .acc          (accB),
        .view         (viewB)
    );

    gpioPinDriver u_pinsB (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET),
        .view         (viewB),
        .afio         (afioB),
        .padIn        (padInB),
        .padOut       (padOutB),
        .padOe        (padOeB),
        .idr          (idrB)
    );

endmodule

`default_nettype wire

// File: gpioRouterTb.sv
`timescale 1ns/1ns
`default_nettype none

module gpioRouterTb
    import gpioPkg::*;
();

    localparam int readyTimeout = 16;  // cycles allowed for PREADY

    logic        io_apb_PCLK;
    logic        io_apb_PRESET;
    logic [15:0] io_apb_PADDR;
    logic        io_apb_PSEL;
    logic        io_apb_PENABLE;
    logic        io_apb_PWRITE;
    logic [31:0] io_apb_PWDATA;
    logic        io_apb_PREADY;
    logic [31:0] io_apb_PRDATA;
    logic        io_apb_PSLVERROR;
    logic [15:0] afioA;
    logic [15:0] afioB;
    logic [15:0] padInA;
    logic [15:0] padInB;
    logic [15:0] padOutA;
    logic [15:0] padOutB;
    logic [15:0] padOeA;
    logic [15:0] padOeB;

    // expected register state per port
    logic [31:0] mCrl [2];
    logic [31:0] mCrh [2];
    logic [15:0] mOdr [2];
    logic [16:0] mLckr [2];
    logic [15:0] mIdr [2];   // last level driven on padIn
    logic [31:0] lfsrState;
    string       testName;
    int          testErrors;
    int          passCount;
    int          failCount;

    gpioRouter u_gpioRouter (.*);

    always #50 io_apb_PCLK = ~io_apb_PCLK;  // 100 ns period

    // galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // applies one access to the model, gives expected PRDATA and error
    function automatic logic [31:0] refAccess(input logic wr, input logic [3:0] port,
                                              input logic [2:0] slot, input logic [31:0] wdata,
                                              output logic expErr);
        logic [31:0] rd;
        logic [15:0] lockMask;
        int          p;
        rd = '0;
        p = int'(port[0]);
        expErr = (port > 4'd1) || (slot == slotRsvd) || (wr && slot == slotIdr);
        if (expErr)
            return '0;                                 // no state change, reads zero
        lockMask = mLckr[p][15:0];
        if (wr) begin
            case (slot)
                slotCrl: for (int i = 0; i < 8; i++) begin
                    if (!lockMask[i])
                        mCrl[p][4*i +: 4] = wdata[4*i +: 4];
                end
                slotCrh: for (int i = 0; i < 8; i++) begin
                    if (!lockMask[i + 8])
                        mCrh[p][4*i +: 4] = wdata[4*i +: 4];
                end
                slotOdr:  mOdr[p] = wdata[15:0];
                slotBsrr: for (int i = 0; i < 16; i++) begin
                    if (wdata[i])
                        mOdr[p][i] = 1'b1;             // set wins
                    else if (wdata[16 + i])
                        mOdr[p][i] = 1'b0;
                end
                slotBrr: for (int i = 0; i < 16; i++) begin
                    if (wdata[i])
                        mOdr[p][i] = 1'b0;
                end
                slotLckr: begin
                    if (!mLckr[p][16] && wdata[16])
                        mLckr[p] = wdata[16:0];
                end
                default: ;
            endcase
        end else begin
            case (slot)
                slotCrl:  rd = mCrl[p];
                slotCrh:  rd = mCrh[p];
                slotIdr:  rd = {16'd0, mIdr[p]};
                slotOdr:  rd = {16'd0, mOdr[p]};
                slotLckr: rd = {15'd0, mLckr[p]};
                default:  rd = '0;                     // BSRR and BRR
            endcase
        end
        return rd;
    endfunction

    // expected pads of one port as {padOe, padOut}
    function automatic logic [31:0] expPads(input int p, input logic [15:0] afio);
        logic [3:0]  nib;
        logic        src;
        logic [15:0] out;
        logic [15:0] oe;
        for (int i = 0; i < 16; i++) begin
            nib = (i < 8) ? mCrl[p][4*i +: 4] : mCrh[p][4*(i-8) +: 4];
            src = nib[3] ? afio[i] : mOdr[p][i];
            if (nib[1:0] == 2'b00) begin
                oe[i]  = 1'b0;                         // input
                out[i] = 1'b0;
            end else if (nib[2]) begin
                oe[i]  = ~src;                         // open drain pulls low only
                out[i] = 1'b0;
            end else begin
                oe[i]  = 1'b1;
                out[i] = src;
            end
        end
        return {oe, out};
    endfunction

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++)
            @(negedge io_apb_PCLK);
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %h actual %h", testName, what, exp, act);
            testErrors++;
        end
    endtask

    // setup phase, access phase, then idle
    task automatic apbAccess(input logic wr, input logic [3:0] port, input logic [2:0] slot,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int waitCount;
        @(negedge io_apb_PCLK);
        io_apb_PADDR   = {port, 7'd0, slot, 2'd0};
        io_apb_PWRITE  = wr;
        io_apb_PWDATA  = wdata;
        io_apb_PSEL    = 1'b1;
        io_apb_PENABLE = 1'b0;
        @(negedge io_apb_PCLK);
        io_apb_PENABLE = 1'b1;
        #10;                                           // let PRDATA settle
        waitCount = 0;
        while (io_apb_PREADY !== 1'b1 && waitCount < readyTimeout) begin
            @(negedge io_apb_PCLK);
            #10;
            waitCount++;
        end
        if (io_apb_PREADY !== 1'b1) begin
            $display("timeout: PREADY stayed low for %0d cycles", readyTimeout);
            $display("TEST FAIL");
            $finish;
        end else begin
            rdata = io_apb_PRDATA;
            err   = io_apb_PSLVERROR;
            @(negedge io_apb_PCLK);
            io_apb_PSEL    = 1'b0;
            io_apb_PENABLE = 1'b0;
            io_apb_PWRITE  = 1'b0;
        end
    endtask

    task automatic apbWrite(input logic [3:0] port, input logic [2:0] slot,
                            input logic [31:0] wdata, output logic err);
        logic [31:0] unused;
        apbAccess(1'b1, port, slot, wdata, unused, err);
    endtask

    task automatic apbRead(input logic [3:0] port, input logic [2:0] slot,
                           output logic [31:0] rdata, output logic err);
        apbAccess(1'b0, port, slot, 32'd0, rdata, err);
    endtask

    // one bus access checked against the model
    task automatic transfer(input string what, input logic wr, input logic [3:0] port,
                            input logic [2:0] slot, input logic [31:0] wdata);
        logic [31:0] actData;
        logic        actErr;
        logic [31:0] expData;
        logic        expErr;
        expData = refAccess(wr, port, slot, wdata, expErr);
        if (wr) begin
            apbWrite(port, slot, wdata, actErr);
        end else begin
            apbRead(port, slot, actData, actErr);
            compare({what, " PRDATA"}, expData, actData);
        end
        compare({what, " PSLVERROR"}, {31'd0, expErr}, {31'd0, actErr});
    endtask

    // pads settle well before the falling edge
    task automatic checkPads();
        logic [31:0] expA;
        logic [31:0] expB;
        expA = expPads(0, afioA);
        expB = expPads(1, afioB);
        compare("padOutA", {16'd0, expA[15:0]}, {16'd0, padOutA});
        compare("padOeA", {16'd0, expA[31:16]}, {16'd0, padOeA});
        compare("padOutB", {16'd0, expB[15:0]}, {16'd0, padOutB});
        compare("padOeB", {16'd0, expB[31:16]}, {16'd0, padOeB});
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
            passCount++;
        end else begin
            $display("test %s: %0d errors", testName, testErrors);
            failCount++;
        end
    endtask

    initial begin
        logic [3:0] port;
        logic [2:0] slot;
        lfsrState      = 32'h56397b67;
        passCount      = 0;
        failCount      = 0;
        io_apb_PCLK    = 1'b0;
        io_apb_PRESET  = 1'b1;
        io_apb_PADDR   = '0;
        io_apb_PSEL    = 1'b0;
        io_apb_PENABLE = 1'b0;
        io_apb_PWRITE  = 1'b0;
        io_apb_PWDATA  = '0;
        afioA          = '0;
        afioB          = '0;
        padInA         = '0;
        padInB         = '0;
        for (int p = 0; p < 2; p++) begin
            mCrl[p]  = '0;
            mCrh[p]  = '0;
            mOdr[p]  = '0;
            mLckr[p] = '0;
            mIdr[p]  = '0;
        end
        waitCycles(10);
        io_apb_PRESET = 1'b0;

        startTest("register readback");
        for (int p = 0; p < 2; p++) begin
            transfer("CRL write", 1'b1, 4'(p), slotCrl, randBits(32));
            transfer("CRH write", 1'b1, 4'(p), slotCrh, randBits(32));
            transfer("ODR write", 1'b1, 4'(p), slotOdr, randBits(32));  // upper half dropped
        end
        for (int p = 0; p < 2; p++) begin
            transfer("CRL read", 1'b0, 4'(p), slotCrl, 32'd0);
            transfer("CRH read", 1'b0, 4'(p), slotCrh, 32'd0);
            transfer("ODR read", 1'b0, 4'(p), slotOdr, 32'd0);
            transfer("BSRR read", 1'b0, 4'(p), slotBsrr, 32'd0);
            transfer("BRR read", 1'b0, 4'(p), slotBrr, 32'd0);
        end
        finishTest();

        startTest("bit set and reset");
        for (int n = 0; n < 12; n++) begin
            port = 4'(randBits(1));
            slot = randBits(1) ? slotBsrr : slotBrr;
            transfer("set/reset write", 1'b1, port, slot, randBits(32));
            transfer("ODR A read", 1'b0, 4'd0, slotOdr, 32'd0);  // other port must hold
            transfer("ODR B read", 1'b0, 4'd1, slotOdr, 32'd0);
        end
        finishTest();

        startTest("pad drive");
        for (int n = 0; n < 8; n++) begin
            afioA = 16'(randBits(16));
            afioB = 16'(randBits(16));
            for (int p = 0; p < 2; p++) begin
                transfer("CRL write", 1'b1, 4'(p), slotCrl, randBits(32));
                transfer("CRH write", 1'b1, 4'(p), slotCrh, randBits(32));
                transfer("ODR write", 1'b1, 4'(p), slotOdr, randBits(32));
            end
            waitCycles(1);
            checkPads();
        end
        finishTest();

        startTest("input sampling");
        for (int n = 0; n < 4; n++) begin
            transfer("CRL write", 1'b1, 4'd0, slotCrl, randBits(32));  // vary the modes
            transfer("CRH write", 1'b1, 4'd1, slotCrh, randBits(32));
            padInA  = 16'(randBits(16));
            padInB  = 16'(randBits(16));
            mIdr[0] = padInA;
            mIdr[1] = padInB;
            waitCycles(3);                             // two sync flops plus margin
            transfer("IDR A read", 1'b0, 4'd0, slotIdr, 32'd0);
            transfer("IDR B read", 1'b0, 4'd1, slotIdr, 32'd0);
        end
        finishTest();

        startTest("configuration lock");
        for (int p = 0; p < 2; p++) begin
            transfer("LCKR key write", 1'b1, 4'(p), slotLckr, {15'd0, 1'b1, 16'(randBits(16))});
            transfer("LCKR read", 1'b0, 4'(p), slotLckr, 32'd0);
            transfer("CRL write", 1'b1, 4'(p), slotCrl, randBits(32));
            transfer("CRH write", 1'b1, 4'(p), slotCrh, randBits(32));
            transfer("CRL read", 1'b0, 4'(p), slotCrl, 32'd0);
            transfer("CRH read", 1'b0, 4'(p), slotCrh, 32'd0);
            transfer("LCKR rewrite", 1'b1, 4'(p), slotLckr, randBits(32) | 32'h0001_0000);
            transfer("LCKR reread", 1'b0, 4'(p), slotLckr, 32'd0);
        end
        finishTest();

        startTest("errors");
        for (int p = 2; p < 16; p++) begin
            transfer("unmapped port read", 1'b0, 4'(p), 3'(randBits(3)), 32'd0);
            transfer("unmapped port write", 1'b1, 4'(p), 3'(randBits(3)), randBits(32));
        end
        for (int p = 0; p < 2; p++) begin
            transfer("slot 7 read", 1'b0, 4'(p), slotRsvd, 32'd0);
            transfer("slot 7 write", 1'b1, 4'(p), slotRsvd, randBits(32));
            transfer("IDR write", 1'b1, 4'(p), slotIdr, randBits(32));
        end
        for (int p = 0; p < 2; p++) begin
            transfer("CRL after errors", 1'b0, 4'(p), slotCrl, 32'd0);
            transfer("CRH after errors", 1'b0, 4'(p), slotCrh, 32'd0);
            transfer("ODR after errors", 1'b0, 4'(p), slotOdr, 32'd0);
            transfer("LCKR after errors", 1'b0, 4'(p), slotLckr, 32'd0);
        end
        finishTest();

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# build and run the GPIO router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f gpioRouter.f \
    --top-module gpioRouterTb \
    -o gpioRouterSim

./obj_dir/gpioRouterSim | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
